// ==== include/mips_defines.svh ====
`ifndef MIPS_DEFINES_SVH
`define MIPS_DEFINES_SVH

// First fetch address out of reset
`define MIPS_RESET_VECTOR 32'hbfc00000
// Fetching from here ends the run
`define MIPS_HALT_ADDR    32'h00000000

// Primary opcodes, instruction bits 31:26
`define OP_RTYPE 6'h00
`define OP_J     6'h02
`define OP_BEQ   6'h04
`define OP_BNE   6'h05
`define OP_ADDIU 6'h09
`define OP_ORI   6'h0d
`define OP_LW    6'h23
`define OP_SW    6'h2b

// R-type function codes, bits 5:0
`define FN_JR    6'h08
`define FN_ADDU  6'h21
`define FN_SUBU  6'h23
`define FN_AND   6'h24
`define FN_OR    6'h25
`define FN_SLT   6'h2a

`endif

// ==== verilog/mips_pkg.sv ====
`default_nettype none

package mips_pkg;

	// Register-format view of an instruction word
	// Immediate and jump index overlap the low bits
	typedef struct packed {
		logic [5:0] opcode;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} instr_t;

	// Operations the ALU knows
	typedef enum logic [2:0] {
		alu_add = 3'd0,
		alu_sub = 3'd1,
		alu_and = 3'd2,
		alu_or  = 3'd3,
		alu_slt = 3'd4
	} alu_op_t;

	// Decoded control word, all zero means no effect
	typedef struct packed {
		logic    reg_write;
		logic    reg_dst;
		logic    alu_src_imm;
		logic    imm_zero_ext;
		logic    mem_read;
		logic    mem_write;
		logic    mem_to_reg;
		logic    branch_eq;
		logic    branch_ne;
		logic    jump;
		logic    jump_reg;
		alu_op_t alu_op;
	} ctrl_t;

endpackage

`default_nettype wire

// ==== verilog/mips_control.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mips_defines.svh"

module mips_control (
	input  logic [5:0]      opcode,
	input  logic [5:0]      funct,
	output mips_pkg::ctrl_t ctrl
);
	import mips_pkg::*;

	always_comb begin
		// Unknown codes fall through as a no-op
		ctrl = '0;
		case (opcode)
			`OP_RTYPE: begin
				// Result goes to rd for the ALU ops
				ctrl.reg_dst = 1'b1;
				case (funct)
					`FN_ADDU: begin
						ctrl.reg_write = 1'b1;
						ctrl.alu_op = alu_add;
					end
					`FN_SUBU: begin
						ctrl.reg_write = 1'b1;
						ctrl.alu_op = alu_sub;
					end
					`FN_AND: begin
						ctrl.reg_write = 1'b1;
						ctrl.alu_op = alu_and;
					end
					`FN_OR: begin
						ctrl.reg_write = 1'b1;
						ctrl.alu_op = alu_or;
					end
					`FN_SLT: begin
						ctrl.reg_write = 1'b1;
						ctrl.alu_op = alu_slt;
					end
					// Redirects fetch without a register write
					`FN_JR: ctrl.jump_reg = 1'b1;
					default: ctrl = '0;
				endcase
			end
			`OP_ADDIU: begin
				ctrl.reg_write = 1'b1;
				ctrl.alu_src_imm = 1'b1;
				ctrl.alu_op = alu_add;
			end
			`OP_ORI: begin
				// Logical immediate needs no sign extension
				ctrl.reg_write = 1'b1;
				ctrl.alu_src_imm = 1'b1;
				ctrl.imm_zero_ext = 1'b1;
				ctrl.alu_op = alu_or;
			end
			`OP_LW: begin
				ctrl.reg_write = 1'b1;
				ctrl.alu_src_imm = 1'b1;
				ctrl.mem_read = 1'b1;
				ctrl.mem_to_reg = 1'b1;
				ctrl.alu_op = alu_add;
			end
			`OP_SW: begin
				// Base plus offset gives the store address
				ctrl.alu_src_imm = 1'b1;
				ctrl.mem_write = 1'b1;
				ctrl.alu_op = alu_add;
			end
			`OP_BEQ: begin
				ctrl.branch_eq = 1'b1;
				ctrl.alu_op = alu_sub;
			end
			`OP_BNE: begin
				ctrl.branch_ne = 1'b1;
				ctrl.alu_op = alu_sub;
			end
			`OP_J: ctrl.jump = 1'b1;
			default: ctrl = '0;
		endcase
	end

endmodule

`default_nettype wire

// ==== verilog/mips_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module mips_alu (
	input  logic [31:0]     a,
	input  logic [31:0]     b,
	input  mips_pkg::ctrl_t ctrl,
	output logic [31:0]     result,
	output logic            take_branch
);
	import mips_pkg::*;

	logic equal;

	always_comb begin
		case (ctrl.alu_op)
			alu_add: result = a + b;
			alu_sub: result = a - b;
			alu_and: result = a & b;
			alu_or:  result = a | b;
			// Signed compare gives 0 or 1
			alu_slt: result = {31'b0, $signed(a) < $signed(b)};
			default: result = a + b;
		endcase
	end

	// Branch compares rs against rt
	assign equal = (a == b);

	// BEQ takes equal operands and BNE unequal ones
	assign take_branch = (ctrl.branch_eq && equal) || (ctrl.branch_ne && !equal);

endmodule

`default_nettype wire

// ==== verilog/mips_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

module mips_regfile (
	input  logic        clk,
	input  logic        reset,
	input  logic        enable,
	input  logic        write_en,
	input  logic [4:0]  read_reg1,
	input  logic [4:0]  read_reg2,
	input  logic [4:0]  write_reg,
	input  logic [31:0] write_data,
	output logic [31:0] read_data1,
	output logic [31:0] read_data2,
	output logic [31:0] register_v0
);

	logic [31:0] regs [31:0];

	always_ff @(posedge clk) begin
		if (reset) begin
			// Every program starts from a clean file
			for (int i = 0; i < 32; i++) begin
				regs[i] <= 32'b0;
			end
		end else if (enable && write_en && (write_reg != 5'd0)) begin
			// r0 never takes a write
			regs[write_reg] <= write_data;
		end
	end

	// Combinational read ports
	assign read_data1 = regs[read_reg1];
	assign read_data2 = regs[read_reg2];

	// v0 for the outside world
	assign register_v0 = regs[2];

endmodule

`default_nettype wire

// ==== verilog/mips_pc.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mips_defines.svh"

module mips_pc (
	input  logic            clk,
	input  logic            reset,
	input  logic            clk_enable,
	input  mips_pkg::ctrl_t ctrl,
	input  logic            take_branch,
	input  logic [15:0]     imm,
	input  logic [25:0]     jump_index,
	input  logic [31:0]     rs_data,
	output logic [31:0]     pc,
	output logic            active
);

	typedef enum logic {
		st_running = 1'b0,
		st_halted  = 1'b1
	} run_state_t;

	run_state_t state;
	logic [31:0] pc_plus4;
	logic [31:0] branch_offset;
	logic [31:0] next_pc;

	assign pc_plus4 = pc + 32'd4;

	// Sign-extended word offset
	assign branch_offset = {{14{imm[15]}}, imm, 2'b00};

	// JR first, then J, then a taken branch
	always_comb begin
		if (ctrl.jump_reg) begin
			next_pc = rs_data;
		end else if (ctrl.jump) begin
			next_pc = {pc_plus4[31:28], jump_index, 2'b00};
		end else if (take_branch) begin
			next_pc = pc_plus4 + branch_offset;
		end else begin
			next_pc = pc_plus4;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= st_running;
			pc <= `MIPS_RESET_VECTOR;
		end else if (clk_enable && state == st_running) begin
			// Freeze once the halt address is reached
			if (pc == `MIPS_HALT_ADDR)
				state <= st_halted;
			else
				pc <= next_pc;
		end
	end

	assign active = (state == st_running);

	// Fetch stays word aligned while running
	assert property (@(posedge clk) disable iff (reset) active |-> (pc[1:0] == 2'b00))
		else $error("pc: unaligned fetch address %h", pc);

endmodule

`default_nettype wire

// ==== verilog/mips_cpu_harvard.sv ====
`timescale 1ns/1ps
`default_nettype none

module mips_cpu_harvard (
	input  logic        clk,
	input  logic        reset,
	output logic        active,
	output logic [31:0] register_v0,
	input  logic        clk_enable,
	output logic [31:0] instr_address,
	input  logic [31:0] instr_readdata,
	output logic [31:0] data_address,
	output logic        data_write,
	output logic        data_read,
	output logic [31:0] data_writedata,
	input  logic [31:0] data_readdata
);
	import mips_pkg::*;

	instr_t instr;
	ctrl_t ctrl;
	logic [4:0] write_reg;
	logic [31:0] rs_data;
	logic [31:0] rt_data;
	logic [31:0] imm_ext;
	logic [31:0] alu_b;
	logic [31:0] alu_result;
	logic [31:0] write_data;
	logic take_branch;
	logic retire;

	assign instr = instr_t'(instr_readdata);

	// Instruction takes effect only on a live, enabled cycle
	assign retire = active && clk_enable && !reset;

	mips_control u_control (
		.opcode (instr.opcode),
		.funct  (instr.funct),
		.ctrl   (ctrl)
	);

	// rd for R-type, rt for immediates and loads
	assign write_reg = ctrl.reg_dst ? instr.rd : instr.rt;

	// ORI zero-extends, everything else sign-extends
	assign imm_ext = ctrl.imm_zero_ext ? {16'b0, instr_readdata[15:0]} :
		{{16{instr_readdata[15]}}, instr_readdata[15:0]};

	assign alu_b = ctrl.alu_src_imm ? imm_ext : rt_data;

	// Load data or ALU result back to the file
	assign write_data = ctrl.mem_to_reg ? data_readdata : alu_result;

	mips_regfile u_regfile (
		.clk         (clk),
		.reset       (reset),
		.enable      (clk_enable),
		.write_en    (ctrl.reg_write && active && !reset),
		.read_reg1   (instr.rs),
		.read_reg2   (instr.rt),
		.write_reg   (write_reg),
		.write_data  (write_data),
		.read_data1  (rs_data),
		.read_data2  (rt_data),
		.register_v0 (register_v0)
	);

	mips_alu u_alu (
		.a           (rs_data),
		.b           (alu_b),
		.ctrl        (ctrl),
		.result      (alu_result),
		.take_branch (take_branch)
	);

	mips_pc u_pc (
		.clk         (clk),
		.reset       (reset),
		.clk_enable  (clk_enable),
		.ctrl        (ctrl),
		.take_branch (take_branch),
		.imm         (instr_readdata[15:0]),
		.jump_index  (instr_readdata[25:0]),
		.rs_data     (rs_data),
		.pc          (instr_address),
		.active      (active)
	);

	// Data port, strobes only while retiring
	assign data_address = alu_result;
	assign data_writedata = rt_data;
	assign data_read = ctrl.mem_read && retire;
	assign data_write = ctrl.mem_write && retire;

endmodule

`default_nettype wire

// ==== bench/mips_mem_model.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mips_defines.svh"

module mips_mem_model (
	input  logic        clk,
	input  logic        clear_ram,
	input  logic [31:0] instr_address,
	output logic [31:0] instr_readdata,
	input  logic [31:0] data_address,
	input  logic        data_write,
	input  logic        data_read,
	input  logic [31:0] data_writedata,
	output logic [31:0] data_readdata
);

	localparam int rom_words = 16;
	localparam int ram_words = 16;

	// Program words, filled in by the testbench
	logic [31:0] rom [rom_words];
	logic [31:0] ram [ram_words];
	logic [31:0] rom_offset;
	logic rom_hit;
	logic ram_hit;

	// ROM window starts at the reset vector
	assign rom_offset = instr_address - `MIPS_RESET_VECTOR;
	assign rom_hit = (rom_offset[31:6] == 26'b0);
	// Outside the window reads zero, a no-op
	assign instr_readdata = rom_hit ? rom[rom_offset[5:2]] : 32'h0;

	// RAM at the bottom of data space
	assign ram_hit = (data_address[31:6] == 26'b0);
	assign data_readdata = (data_read && ram_hit) ? ram[data_address[5:2]] : 32'h0;

	always_ff @(posedge clk) begin
		if (clear_ram) begin
			for (int i = 0; i < ram_words; i++) begin
				ram[i] <= 32'h0;
			end
		end else if (data_write && ram_hit) begin
			ram[data_address[5:2]] <= data_writedata;
		end
	end

endmodule

`default_nettype wire

// ==== bench/mips_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mips_defines.svh"

module mips_tb;

	localparam int num_tests = 7;
	localparam int prog_words = 16;
	// RAM word 4 sits at byte address 0x10
	localparam int check_word = 4;
	localparam int watchdog_ns = num_tests * 64 * 8;

	logic clk = 1'b0;
	logic reset = 1'b1;
	logic clk_enable = 1'b0;
	logic clear_ram = 1'b1;
	logic active;
	logic [31:0] register_v0;
	logic [31:0] instr_address;
	logic [31:0] instr_readdata;
	logic [31:0] data_address;
	logic data_write;
	logic data_read;
	logic [31:0] data_writedata;
	logic [31:0] data_readdata;
	integer seed = 32'hc5b9;

	// Test table
	string names [num_tests];
	logic [31:0] progs [num_tests][prog_words];
	logic [31:0] exp_v0 [num_tests];
	logic [31:0] exp_ram [num_tests];
	logic holes [num_tests];
	int fill_test;
	int fill_pos;

	mips_cpu_harvard UUT (
		.clk            (clk),
		.reset          (reset),
		.active         (active),
		.register_v0    (register_v0),
		.clk_enable     (clk_enable),
		.instr_address  (instr_address),
		.instr_readdata (instr_readdata),
		.data_address   (data_address),
		.data_write     (data_write),
		.data_read      (data_read),
		.data_writedata (data_writedata),
		.data_readdata  (data_readdata)
	);

	mips_mem_model mem (
		.clk            (clk),
		.clear_ram      (clear_ram),
		.instr_address  (instr_address),
		.instr_readdata (instr_readdata),
		.data_address   (data_address),
		.data_write     (data_write),
		.data_read      (data_read),
		.data_writedata (data_writedata),
		.data_readdata  (data_readdata)
	);

	always #4 clk = ~clk;

	function automatic logic [31:0] rtype_word(input logic [4:0] rs, input logic [4:0] rt,
			input logic [4:0] rd, input logic [5:0] fn);
		return {`OP_RTYPE, rs, rt, rd, 5'd0, fn};
	endfunction

	function automatic logic [31:0] itype_word(input logic [5:0] op, input logic [4:0] rs,
			input logic [4:0] rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	// Jump to a word of the program ROM
	function automatic logic [31:0] jump_word(input int word);
		logic [31:0] target;
		target = `MIPS_RESET_VECTOR + 32'(word * 4);
		return {`OP_J, target[27:2]};
	endfunction

	task automatic compare_word(input string test_name, input string what,
			input logic [31:0] expected, input logic [31:0] actual);
		if (expected !== actual) begin
			$display("ERROR %s %s expected %h actual %h", test_name, what, expected, actual);
			$display("ERRORS FOUND");
			$fatal(1, "mismatch in %s", test_name);
		end
	endtask

	task automatic start_entry(input int t, input string name, input logic [31:0] v0,
			input logic [31:0] ram_word, input logic use_holes);
		fill_test = t;
		fill_pos = 0;
		names[t] = name;
		exp_v0[t] = v0;
		exp_ram[t] = ram_word;
		holes[t] = use_holes;
		// Unused words fetch as no-ops
		for (int w = 0; w < prog_words; w++) begin
			progs[t][w] = 32'h0;
		end
	endtask

	task automatic push_instr(input logic [31:0] word);
		progs[fill_test][fill_pos] = word;
		fill_pos++;
	endtask

	// Same program and results with stalls added
	task automatic copy_entry(input int src, input int dst, input string name);
		start_entry(dst, name, exp_v0[src], exp_ram[src], 1'b1);
		for (int w = 0; w < prog_words; w++) begin
			progs[dst][w] = progs[src][w];
		end
	endtask

	task automatic build_table();
		// v0 = 7 + 17 + 1 + 23 + 1 - 0 + (-5)
		start_entry(0, "arith", 32'h0000002c, 32'h0, 1'b0);
		push_instr(itype_word(`OP_ADDIU, 5'd0, 5'd8, 16'hfffb));
		push_instr(itype_word(`OP_ADDIU, 5'd0, 5'd9, 16'd12));
		push_instr(rtype_word(5'd8, 5'd9, 5'd10, `FN_ADDU));
		push_instr(rtype_word(5'd9, 5'd8, 5'd11, `FN_SUBU));
		push_instr(rtype_word(5'd10, 5'd11, 5'd12, `FN_AND));
		push_instr(rtype_word(5'd10, 5'd11, 5'd13, `FN_OR));
		// Signed compare with -5 below 12
		push_instr(rtype_word(5'd8, 5'd9, 5'd14, `FN_SLT));
		push_instr(rtype_word(5'd9, 5'd8, 5'd15, `FN_SLT));
		push_instr(rtype_word(5'd10, 5'd11, 5'd2, `FN_ADDU));
		push_instr(rtype_word(5'd2, 5'd12, 5'd2, `FN_ADDU));
		push_instr(rtype_word(5'd2, 5'd13, 5'd2, `FN_ADDU));
		push_instr(rtype_word(5'd2, 5'd14, 5'd2, `FN_ADDU));
		push_instr(rtype_word(5'd2, 5'd15, 5'd2, `FN_SUBU));
		push_instr(rtype_word(5'd2, 5'd8, 5'd2, `FN_ADDU));
		push_instr(rtype_word(5'd0, 5'd0, 5'd0, `FN_JR));
		// 0x00008001 minus 0xffff8001
		start_entry(1, "ori_vs_addiu", 32'h00010000, 32'h0, 1'b0);
		push_instr(itype_word(`OP_ORI, 5'd0, 5'd8, 16'h8001));
		push_instr(itype_word(`OP_ADDIU, 5'd0, 5'd9, 16'h8001));
		push_instr(rtype_word(5'd8, 5'd9, 5'd2, `FN_SUBU));
		push_instr(rtype_word(5'd0, 5'd0, 5'd0, `FN_JR));
		// Stored word is 0xfffffffe - 0x1234
		start_entry(2, "store_load", 32'hffffedca, 32'hffffedca, 1'b0);
		// Store sits at the reset vector so data_write must stay low in reset
		push_instr(itype_word(`OP_SW, 5'd0, 5'd0, 16'h0014));
		push_instr(itype_word(`OP_ADDIU, 5'd0, 5'd9, 16'd8));
		push_instr(itype_word(`OP_ORI, 5'd0, 5'd8, 16'h1234));
		push_instr(itype_word(`OP_ADDIU, 5'd0, 5'd10, 16'hfffe));
		push_instr(rtype_word(5'd10, 5'd8, 5'd11, `FN_SUBU));
		push_instr(itype_word(`OP_SW, 5'd9, 5'd11, 16'd8));
		push_instr(itype_word(`OP_LW, 5'd9, 5'd2, 16'd8));
		push_instr(rtype_word(5'd0, 5'd0, 5'd0, `FN_JR));
		// Markers 0x02, 0x08 and 0x20 run and the rest are skipped
		start_entry(3, "branches", 32'h0000002a, 32'h0, 1'b0);
		push_instr(itype_word(`OP_ADDIU, 5'd0, 5'd8, 16'd5));
		push_instr(itype_word(`OP_ADDIU, 5'd0, 5'd9, 16'd5));
		push_instr(itype_word(`OP_ADDIU, 5'd0, 5'd10, 16'd6));
		push_instr(itype_word(`OP_BEQ, 5'd8, 5'd9, 16'd1));
		push_instr(itype_word(`OP_ORI, 5'd2, 5'd2, 16'h0001));
		push_instr(itype_word(`OP_BEQ, 5'd8, 5'd10, 16'd1));
		push_instr(itype_word(`OP_ORI, 5'd2, 5'd2, 16'h0002));
		push_instr(itype_word(`OP_BNE, 5'd8, 5'd10, 16'd1));
		push_instr(itype_word(`OP_ORI, 5'd2, 5'd2, 16'h0004));
		push_instr(itype_word(`OP_BNE, 5'd8, 5'd9, 16'd1));
		push_instr(itype_word(`OP_ORI, 5'd2, 5'd2, 16'h0008));
		push_instr(jump_word(13));
		push_instr(itype_word(`OP_ORI, 5'd2, 5'd2, 16'h0010));
		push_instr(itype_word(`OP_ORI, 5'd2, 5'd2, 16'h0020));
		push_instr(rtype_word(5'd0, 5'd0, 5'd0, `FN_JR));
		// Writes to r0 must not leak into the sum
		start_entry(4, "r0_write", 32'h00000100, 32'h0, 1'b0);
		// Load at the reset vector so data_read must stay low in reset
		push_instr(itype_word(`OP_LW, 5'd0, 5'd0, 16'h0010));
		push_instr(itype_word(`OP_ADDIU, 5'd0, 5'd0, 16'h0055));
		push_instr(itype_word(`OP_ORI, 5'd0, 5'd0, 16'h0007));
		push_instr(itype_word(`OP_ADDIU, 5'd0, 5'd2, 16'h0100));
		push_instr(rtype_word(5'd2, 5'd0, 5'd2, `FN_ADDU));
		push_instr(rtype_word(5'd0, 5'd0, 5'd0, `FN_JR));
		copy_entry(2, 5, "store_load_holes");
		copy_entry(3, 6, "branches_holes");
	endtask

	task automatic run_entry(input int t);
		@(posedge clk);
		#1;
		reset = 1'b1;
		clear_ram = 1'b1;
		clk_enable = 1'b1;
		// Load while the CPU sits in reset
		for (int w = 0; w < prog_words; w++) begin
			mem.rom[w] = progs[t][w];
		end
		repeat (5) @(posedge clk);
		#1;
		compare_word(names[t], "reset pc", `MIPS_RESET_VECTOR, instr_address);
		compare_word(names[t], "reset active", 32'h1, {31'b0, active});
		compare_word(names[t], "reset data_write", 32'h0, {31'b0, data_write});
		compare_word(names[t], "reset data_read", 32'h0, {31'b0, data_read});
		reset = 1'b0;
		clear_ram = 1'b0;
		while (active) begin
			@(posedge clk);
			#1;
			// About one stall cycle in four
			if (holes[t])
				clk_enable = (($random(seed) & 3) != 0);
			else
				clk_enable = 1'b1;
		end
		// Halted CPU must stay put
		clk_enable = 1'b1;
		repeat (4) @(posedge clk);
		#1;
		compare_word(names[t], "active after halt", 32'h0, {31'b0, active});
		compare_word(names[t], "v0", exp_v0[t], register_v0);
		compare_word(names[t], "ram word", exp_ram[t], mem.ram[check_word]);
	endtask

	initial begin
		build_table();
		for (int t = 0; t < num_tests; t++) begin
			run_entry(t);
		end
		$display("NO ERRORS");
		$finish;
	end

	// Allows 64 cycles per program
	initial begin
		#(watchdog_ns);
		$display("Timeout: the CPU never halted within the time limit");
		$display("ERRORS FOUND");
		$fatal(1, "watchdog expired");
	end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+include
verilog/mips_pkg.sv
verilog/mips_control.sv
verilog/mips_alu.sv
verilog/mips_regfile.sv
verilog/mips_pc.sv
verilog/mips_cpu_harvard.sv
bench/mips_mem_model.sv
bench/mips_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build the CPU testbench with Verilator, run it and scan the log

set -u
cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
build_log=build.log
sim_log=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f all.f --top-module mips_tb -Mdir "$build_dir" -o mips_tb_sim > "$build_log" 2>&1
if [ $? -ne 0 ]; then
	cat "$build_log"
	echo "Verilator build failed"
	exit 1
fi

"./$build_dir/mips_tb_sim" > "$sim_log" 2>&1
sim_status=$?
cat "$sim_log"

if grep -q "ERRORS FOUND" "$sim_log"; then
	exit 1
fi
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi
exit 0
